/* design/memPkg.sv */
`default_nettype none

package memPkg;

    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;

    // access length in bytes, legal values 1, 2 and 4
    typedef logic [2:0] lenT;

    // byte stage within an access, 0 to 4
    typedef logic [2:0] stageT;

    typedef enum logic [1:0] {
        accIdle,
        accFetch,
        accLoad,
        accStore
    } accessE;

    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } busOwnerE;

    typedef enum logic {
        memRead  = 1'b0,
        memWrite = 1'b1
    } memOpE;

endpackage

`default_nettype wire

/* design/accessSequencer.sv */
`default_nettype none

module accessSequencer (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             rdy,
    input  wire logic             ioBufferFull,
    input  wire logic             fetchEn,
    input  wire logic             dataEn,
    input  wire logic             dataStore,
    input  wire memPkg::lenT      dataLen,
    output memPkg::accessE        state,
    output memPkg::stageT         stage,
    output logic                  accept,
    output logic                  stall,
    output logic                  fetchDone,
    output logic                  dataDone,
    output memPkg::busOwnerE      busOwner
);

    import memPkg::*;

    accessE stateQ;
    accessE reqState;
    stageT  stageQ;
    stageT  lastStage;
    lenT    lenQ;
    lenT    effLen;
    logic   done;

    assign stall = ~rdy | ioBufferFull;

    // arbitration only from idle, data port has priority
    assign accept = (stateQ == accIdle) && !stall && (fetchEn || dataEn);

    always_comb begin
        if (dataEn) begin
            reqState = dataStore ? accStore : accLoad;
        end else begin
            reqState = accFetch;
        end
    end

    // the accept cycle already counts as stage 0 of the new access
    assign state  = accept ? reqState : stateQ;
    assign stage  = stageQ;
    assign effLen = accept ? dataLen : lenQ;

    always_comb begin
        case (state)
            accFetch: lastStage = 3'd4;
            accLoad:  lastStage = effLen;
            accStore: lastStage = effLen - 3'd1;
            default:  lastStage = 3'd0;
        endcase
    end

    assign done      = !stall && (state != accIdle) && (stage == lastStage);
    assign fetchDone = done && (state == accFetch);
    assign dataDone  = done && ((state == accLoad) || (state == accStore));

    always_comb begin
        case (state)
            accFetch:         busOwner = ownerFetch;
            accLoad, accStore: busOwner = ownerData;
            default:          busOwner = ownerNone;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stateQ <= accIdle;
            stageQ <= 3'd0;
            lenQ   <= 3'd4;
        end else if (!stall) begin
            if (accept) begin
                lenQ <= dataLen;
            end
            if (done) begin
                stateQ <= accIdle;
                stageQ <= 3'd0;
            end else if (state != accIdle) begin
                stateQ <= state;
                stageQ <= stage + 3'd1;
            end
        end
    end

    // one client finishes at a time
    assert property (@(posedge clk) disable iff (rst)
        !(fetchDone && dataDone));

    // a frozen cycle never completes an access
    assert property (@(posedge clk) disable iff (rst)
        stall |-> !(fetchDone || dataDone));

endmodule

`default_nettype wire

/* design/readAssembler.sv */
`default_nettype none

module readAssembler (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire memPkg::accessE              state,
    input  wire memPkg::stageT               stage,
    input  wire logic                        stall,
    input  wire memPkg::lenT                 dataLen,
    input  wire logic [memPkg::BYTE_W-1:0]   memDin,
    output logic [memPkg::WORD_W-1:0]        fetchInst,
    output logic [memPkg::WORD_W-1:0]        dataRdata
);

    import memPkg::*;

    logic [3*BYTE_W-1:0] holdQ;
    logic [WORD_W-1:0]   assembled;
    logic [1:0]          lane;
    lenT                 lenQ;
    logic                reading;

    assign reading = (state == accFetch) || (state == accLoad);

    // memDin carries the byte addressed one stage earlier
    assign lane = 2'(stage - 3'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            lenQ <= 3'd4;
        end else if (!stall && reading && stage == 3'd0) begin
            lenQ <= dataLen;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && reading) begin
            if (stage == 3'd0) begin
                holdQ <= '0;
            end else if (stage <= 3'd3) begin
                holdQ[BYTE_W*lane +: BYTE_W] <= memDin;
            end
        end
    end

    // lanes above the current one are still clear
    always_comb begin
        assembled = {{BYTE_W{1'b0}}, holdQ};
        if (stage != 3'd0) begin
            assembled[BYTE_W*lane +: BYTE_W] = memDin;
        end
    end

    assign fetchInst = (state == accFetch && stage == 3'd4) ? assembled : '0;
    assign dataRdata = (state == accLoad && stage == lenQ) ? assembled : '0;

    assert property (@(posedge clk) disable iff (rst)
        (state == accLoad && stage != 3'd0) |-> (lenQ inside {3'd1, 3'd2, 3'd4}));

endmodule

`default_nettype wire

/* design/ramPortDriver.sv */
`default_nettype none

module ramPortDriver (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        accept,
    input  wire memPkg::accessE              state,
    input  wire memPkg::stageT               stage,
    input  wire logic                        stall,
    input  wire logic [memPkg::WORD_W-1:0]   fetchAddr,
    input  wire logic [memPkg::WORD_W-1:0]   dataAddr,
    input  wire logic [memPkg::WORD_W-1:0]   dataWdata,
    output logic [memPkg::ADDR_W-1:0]        memAddr,
    output memPkg::memOpE                    memWe,
    output logic [memPkg::BYTE_W-1:0]        memDout
);

    import memPkg::*;

    logic [ADDR_W-1:0] baseQ;
    logic [WORD_W-1:0] wdataQ;
    logic [ADDR_W-1:0] addrQ;
    logic [ADDR_W-1:0] base;
    logic [WORD_W-1:0] word;
    logic              writing;

    // stage 0 runs in the accept cycle, before the latches are loaded
    assign base = accept ? ((state == accFetch) ? fetchAddr : dataAddr) : baseQ;
    assign word = accept ? dataWdata : wdataQ;

    always_ff @(posedge clk) begin
        if (accept) begin
            baseQ  <= base;
            wdataQ <= dataWdata;
        end
    end

    // last address driven, kept so memDin stays valid across a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            addrQ <= '0;
        end else begin
            addrQ <= memAddr;
        end
    end

    assign memAddr = stall ? addrQ : base + ADDR_W'(stage);

    assign writing = (state == accStore) && !stall;
    assign memWe   = writing ? memWrite : memRead;
    assign memDout = writing ? word[BYTE_W*stage[1:0] +: BYTE_W] : '0;

    assert property (@(posedge clk) disable iff (rst)
        (memWe == memWrite) |-> (state == accStore));

endmodule

`default_nettype wire

/* design/memCtrl.sv */
`default_nettype none

module memCtrl (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        rdy,
    input  wire logic                        ioBufferFull,
    input  wire logic                        fetchEn,
    input  wire logic [memPkg::ADDR_W-1:0]   fetchAddr,
    input  wire logic                        dataEn,
    input  wire logic                        dataStore,
    input  wire memPkg::lenT                 dataLen,
    input  wire logic [memPkg::WORD_W-1:0]   dataWdata,
    input  wire logic [memPkg::ADDR_W-1:0]   dataAddr,
    input  wire logic [memPkg::BYTE_W-1:0]   memDin,
    output logic                             fetchDone,
    output logic [memPkg::WORD_W-1:0]        fetchInst,
    output logic                             dataDone,
    output logic [memPkg::WORD_W-1:0]        dataRdata,
    output memPkg::busOwnerE                 busOwner,
    output logic [memPkg::ADDR_W-1:0]        memAddr,
    output memPkg::memOpE                    memWe,
    output logic [memPkg::BYTE_W-1:0]        memDout
);

    import memPkg::*;

    accessE state;
    stageT  stage;
    logic   accept;
    logic   stall;

    accessSequencer seq_i (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchEn      (fetchEn),
        .dataEn       (dataEn),
        .dataStore    (dataStore),
        .dataLen      (dataLen),
        .state        (state),
        .stage        (stage),
        .accept       (accept),
        .stall        (stall),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .busOwner     (busOwner)
    );

    // byte collection for fetch and load results
    readAssembler asm_i (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .stage     (stage),
        .stall     (stall),
        .dataLen   (dataLen),
        .memDin    (memDin),
        .fetchInst (fetchInst),
        .dataRdata (dataRdata)
    );

    ramPortDriver drv_i (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .state     (state),
        .stage     (stage),
        .stall     (stall),
        .fetchAddr (fetchAddr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memDout   (memDout)
    );

endmodule

`default_nettype wire

/* sim/byteRam.sv */
`default_nettype none

module byteRam (
    input  wire logic        clk,
    input  wire logic [31:0] addr,
    input  wire logic        we,
    input  wire logic [7:0]  din,
    output logic [7:0]       dout
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH = 4096;

    logic [7:0] mem [DEPTH];

    // pattern mixes low and high address bits
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 8'((i * 29) + ((i >> 8) * 7) + 3);
        end
        dout = '0;
    end

    always @(posedge clk) begin
        if (we) begin
            mem[addr[11:0]] <= din;
        end
        dout <= mem[addr[11:0]];
    end

    // little-endian word straight from the array
    function automatic logic [31:0] readWord(logic [31:0] a);
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        a1 = a + 32'd1;
        a2 = a + 32'd2;
        a3 = a + 32'd3;
        return {mem[a3[11:0]], mem[a2[11:0]], mem[a1[11:0]], mem[a[11:0]]};
    endfunction

endmodule

`default_nettype wire

/* sim/memCtrlTb.sv */
`default_nettype none

module memCtrlTb;

    timeunit 1ns;
    timeprecision 1ps;

    import memPkg::*;

    // 22 requests per phase, two phases
    localparam int NUM_REQ = 44;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        ioBufferFull;
    logic        fetchEn;
    logic [31:0] fetchAddr;
    logic        dataEn;
    logic        dataStore;
    lenT         dataLen;
    logic [31:0] dataWdata;
    logic [31:0] dataAddr;
    logic [7:0]  memDin;
    logic        fetchDone;
    logic [31:0] fetchInst;
    logic        dataDone;
    logic [31:0] dataRdata;
    busOwnerE    busOwner;
    logic [31:0] memAddr;
    memOpE       memWe;
    logic [7:0]  memDout;

    logic [31:0] lfsr;
    logic        stallOn;
    logic        stallIn;
    logic [31:0] expFetch;
    logic [31:0] expData;
    logic        expStore;
    logic [2:0]  expCycles;
    logic [2:0]  nsCnt;
    int          errCount;
    int          testNum;
    int          testsFailed;

    memCtrl dut_i (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr), .dataEn(dataEn),
        .dataStore(dataStore), .dataLen(dataLen), .dataWdata(dataWdata),
        .dataAddr(dataAddr), .memDin(memDin), .fetchDone(fetchDone),
        .fetchInst(fetchInst), .dataDone(dataDone), .dataRdata(dataRdata),
        .busOwner(busOwner), .memAddr(memAddr), .memWe(memWe), .memDout(memDout)
    );

    byteRam ram_i (
        .clk(clk), .addr(memAddr), .we(memWe == memWrite), .din(memDout), .dout(memDin)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic lenT pickLen();
        case (2'(randBits(2)))
            2'd0: return 3'd1;
            2'd1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    function automatic logic [31:0] lenMask(lenT len);
        case (len)
            3'd1: return 32'h000000ff;
            3'd2: return 32'h0000ffff;
            default: return 32'hffffffff;
        endcase
    endfunction

    assign stallIn = !rdy || ioBufferFull;

    always @(posedge clk) begin
        if (stallOn) begin
            rdy          <= (3'(randBits(3)) != 3'd0);
            ioBufferFull <= (3'(randBits(3)) == 3'd0);
        end else begin
            rdy          <= 1'b1;
            ioBufferFull <= 1'b0;
        end
    end

    // non-stall cycles spent by the current access before its done cycle
    always @(posedge clk) begin
        if (rst) begin
            nsCnt <= 3'd0;
        end else if (!stallIn) begin
            if (fetchDone || dataDone) begin
                nsCnt <= 3'd0;
            end else if (busOwner != ownerNone) begin
                nsCnt <= nsCnt + 3'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) fetchDone |-> fetchInst == expFetch)
        else begin
            $display("** Error fetchInst got %h expected %h",
                $sampled(fetchInst), $sampled(expFetch));
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst)
        (dataDone && !expStore) |-> dataRdata == expData)
        else begin
            $display("** Error dataRdata got %h expected %h",
                $sampled(dataRdata), $sampled(expData));
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) fetchDone |-> nsCnt == 3'd4)
        else begin
            $display("fetch did not take 5 non-stall cycles");
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) dataDone |-> nsCnt == expCycles)
        else begin
            $display("data access took the wrong number of non-stall cycles");
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) fetchDone |-> busOwner == ownerFetch)
        else begin
            $display("** Error busOwner got %h expected %h",
                $sampled(busOwner), ownerFetch);
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) dataDone |-> busOwner == ownerData)
        else begin
            $display("** Error busOwner got %h expected %h",
                $sampled(busOwner), ownerData);
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst)
        (busOwner == ownerFetch && !fetchDone) |=> busOwner == ownerFetch)
        else begin
            $display("bus owner left the fetch before fetchDone");
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else begin
            $display("fetchDone stayed high for more than one cycle");
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else begin
            $display("dataDone stayed high for more than one cycle");
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst)
        stallIn |-> (memWe == memRead && !fetchDone && !dataDone))
        else begin
            $display("write or done pulse seen during a stall cycle");
            errCount = errCount + 1;
        end

    assert property (@(posedge clk) disable iff (rst) stallIn |-> memAddr == $past(memAddr))
        else begin
            $display("RAM address moved during a stall cycle");
            errCount = errCount + 1;
        end

    task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            $display("** Error %s got %h expected %h", name, got, exp);
            errCount = errCount + 1;
        end
    endtask

    task automatic reportTest(string what, int errsBefore);
        testNum = testNum + 1;
        if (errCount != errsBefore) begin
            testsFailed = testsFailed + 1;
        end
        $display("test %0d %s: %s", testNum, what,
            (errCount == errsBefore) ? "ok" : "FAILED");
    endtask

    task automatic fetchWord(logic [31:0] a);
        int errsBefore;
        errsBefore = errCount;
        @(posedge clk);
        expFetch  <= ram_i.readWord(a);
        fetchAddr <= a;
        fetchEn   <= 1'b1;
        do @(negedge clk); while (!fetchDone);
        @(posedge clk);
        fetchEn <= 1'b0;
        reportTest($sformatf("fetch at %h", a), errsBefore);
    endtask

    task automatic dataAccess(logic store, logic [31:0] a, lenT len, logic [31:0] wd);
        int errsBefore;
        errsBefore = errCount;
        @(posedge clk);
        expData   <= ram_i.readWord(a) & lenMask(len);
        expStore  <= store;
        expCycles <= store ? len - 3'd1 : len;
        dataAddr  <= a;
        dataLen   <= len;
        dataStore <= store;
        dataWdata <= wd;
        dataEn    <= 1'b1;
        do @(negedge clk); while (!dataDone);
        @(posedge clk);
        dataEn <= 1'b0;
        reportTest($sformatf("%s len %0d at %h", store ? "store" : "load", len, a), errsBefore);
    endtask

    // store, check neighbours and merge, then read the word back
    task automatic storeReadBack(logic [31:0] a, lenT len, logic [31:0] wd);
        logic [31:0] oldWord;
        logic [31:0] prevWord;
        logic [31:0] nextWord;
        logic [31:0] merged;
        oldWord  = ram_i.readWord(a);
        prevWord = ram_i.readWord(a - 32'd4);
        nextWord = ram_i.readWord(a + 32'd4);
        merged   = (oldWord & ~lenMask(len)) | (wd & lenMask(len));
        dataAccess(1'b1, a, len, wd);
        @(negedge clk);
        checkEq("stored word", ram_i.readWord(a), merged);
        checkEq("word below store", ram_i.readWord(a - 32'd4), prevWord);
        checkEq("word above store", ram_i.readWord(a + 32'd4), nextWord);
        dataAccess(1'b0, a, 3'd4, 32'd0);
    endtask

    task automatic dualRequest(logic [31:0] fa, logic [31:0] da, lenT len);
        int errsBefore;
        errsBefore = errCount;
        @(posedge clk);
        expFetch  <= ram_i.readWord(fa);
        expData   <= ram_i.readWord(da) & lenMask(len);
        expStore  <= 1'b0;
        expCycles <= len;
        fetchAddr <= fa;
        dataAddr  <= da;
        dataLen   <= len;
        dataStore <= 1'b0;
        fetchEn   <= 1'b1;
        dataEn    <= 1'b1;
        do @(negedge clk); while (!dataDone && !fetchDone);
        assert (dataDone && !fetchDone) else begin
            $display("fetch finished before the data request");
            errCount = errCount + 1;
        end
        @(posedge clk);
        dataEn <= 1'b0;
        do @(negedge clk); while (!fetchDone);
        @(posedge clk);
        fetchEn <= 1'b0;
        reportTest($sformatf("fetch %h with load at %h", fa, da), errsBefore);
    endtask

    task automatic requestPhase();
        for (int i = 0; i < 4; i++) begin
            fetchWord({20'd0, 12'(randBits(12))});
        end
        for (int i = 0; i < 6; i++) begin
            dataAccess(1'b0, {20'd0, 12'(randBits(12))}, pickLen(), 32'd0);
        end
        for (int i = 0; i < 4; i++) begin
            storeReadBack({20'd0, 12'(randBits(12))}, pickLen(), randBits(32));
        end
        for (int i = 0; i < 2; i++) begin
            dualRequest({20'd0, 12'(randBits(12))}, {20'd0, 12'(randBits(12))}, pickLen());
        end
    endtask

    initial begin
        repeat (NUM_REQ * 20 + 40) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Errors found");
        $finish;
    end

    initial begin
        lfsr         = 32'ha26d;
        stallOn      = 1'b0;
        errCount     = 0;
        testNum      = 0;
        testsFailed  = 0;
        expFetch     = '0;
        expData      = '0;
        expStore     = 1'b0;
        expCycles    = 3'd0;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = 3'd4;
        dataWdata    = '0;
        dataAddr     = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkEq("busOwner", 32'(busOwner), 32'(ownerNone));
        checkEq("memWe", 32'(memWe), 32'(memRead));
        checkEq("fetchDone", 32'(fetchDone), 32'd0);
        checkEq("dataDone", 32'(dataDone), 32'd0);
        checkEq("fetchInst", fetchInst, 32'd0);
        checkEq("dataRdata", dataRdata, 32'd0);
        checkEq("memDout", 32'(memDout), 32'd0);
        reportTest("reset values", 0);

        requestPhase();
        stallOn = 1'b1;
        requestPhase();
        stallOn = 1'b0;
        repeat (2) @(posedge clk);

        $display("tests %0d, failed %0d, errors %0d", testNum, testsFailed, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/memPkg.sv
design/accessSequencer.sv
design/readAssembler.sv
design/ramPortDriver.sv
design/memCtrl.sv
sim/byteRam.sv
sim/memCtrlTb.sv

/* build.sh */
#!/bin/sh
# Build and run the memCtrl testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module memCtrlTb --Mdir obj_dir -o memCtrlSim -f all.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/memCtrlSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "^No errors$" "$LOG"
if [ $? -ne 0 ]; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0
